// ==== ibi_pkg.sv ====
package ibi_pkg;

    ////////////////////////////////////////////////////////////
    // Serial block commands
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        REP_START = 3'd0,
        SERIALIZE = 3'd1,
        STOP      = 3'd2,
        PARITY    = 3'd3,                   // Encoding only, never issued here
        DRIVE_LOW = 3'd4
    } ibi_ser_mode_e;

    typedef enum logic [2:0]
    {
        RX_ACK      = 3'd0,
        DESERIALIZE = 3'd1
    } ibi_rx_mode_e;

    ////////////////////////////////////////////////////////////
    // Control bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed
    {
        logic          tx_en;               // Line driver enable
        logic          pp_od;               // 1 push-pull, 0 open-drain
        ibi_ser_mode_e tx_mode;
    } ibi_tx_ctrl_t;

    typedef struct packed
    {
        logic         rx_en;
        ibi_rx_mode_e rx_mode;
    } ibi_rx_ctrl_t;

    // IBI configuration register, ack_en sits in bit 0
    typedef struct packed
    {
        logic [5:0] rsvd;
        logic       payload_en;             // Read payload after the MDB
        logic       ack_en;                 // Controller ACKs the IBI
    } ibi_cfg_t;

    typedef struct packed
    {
        logic        rd_en;
        logic        wr_en;
        logic [11:0] addr;
    } ibi_regf_req_t;

    typedef enum logic [1:0]
    {
        SEL_HOLD = 2'd0,
        SEL_BCR  = 2'd1,
        SEL_MDB  = 2'd2
    } ibi_regf_sel_e;

    // Register map, BCR at DEF_BCR_BASE + 8 * (dyn addr - DEF_FIRST_TGT_ADDR)
    localparam int DEF_FIRST_TGT_ADDR = 7'h08;
    localparam int DEF_BCR_BASE       = 206;
    localparam int DEF_MDB_ADDR       = 107;

endpackage

// ==== ibi_done_align.sv ====
`timescale 1ns/1ns

module ibi_done_align
(
    input  logic i_ibi_clk,
    input  logic i_ibi_rst_n,
    input  logic i_ser_mode_done,
    input  logic i_rx_mode_done,
    output logic o_rx_done_d1,
    output logic o_rx_done_d2,
    output logic o_ser_done_pulse
);

    logic ser_done_prev;

    // Two-stage delay of the deserializer done level
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            o_rx_done_d1 <= 1'b0;
            o_rx_done_d2 <= 1'b0;
        end
        else
        begin
            o_rx_done_d1 <= i_rx_mode_done;
            o_rx_done_d2 <= o_rx_done_d1;
        end
    end

    // Rising edge of serializer done, registered
    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            ser_done_prev    <= 1'b0;
            o_ser_done_pulse <= 1'b0;
        end
        else
        begin
            ser_done_prev    <= i_ser_mode_done;
            o_ser_done_pulse <= i_ser_mode_done & ~ser_done_prev;
        end
    end

    a_ser_pulse_single: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_ser_done_pulse |=> !o_ser_done_pulse);

endmodule

// ==== ibi_regf_port.sv ====
`timescale 1ns/1ns

module ibi_regf_port
#(
    parameter int FIRST_TGT_ADDR = ibi_pkg::DEF_FIRST_TGT_ADDR,
    parameter int BCR_BASE       = ibi_pkg::DEF_BCR_BASE,
    parameter int MDB_ADDR       = ibi_pkg::DEF_MDB_ADDR
)
(
    input  logic                  i_ibi_clk,
    input  logic                  i_ibi_rst_n,
    input  logic [7:0]            i_tgt_address,
    input  ibi_pkg::ibi_regf_sel_e i_regf_sel,
    input  logic                  i_rd_level,
    input  logic                  i_wr_level,
    output ibi_pkg::ibi_regf_req_t o_regf
);

    import ibi_pkg::*;

    logic [6:0]  tgt_index;
    logic [11:0] bcr_addr;
    logic        wr_level_prev;

    ////////////////////////////////////////////////////////////
    // BCR location of the current target
    ////////////////////////////////////////////////////////////

    assign tgt_index = i_tgt_address[7:1] - 7'(FIRST_TGT_ADDR);   // Dynamic address in 7:1
    assign bcr_addr  = 12'(BCR_BASE) + {2'b00, tgt_index, 3'b000}; // Eight registers per target

    ////////////////////////////////////////////////////////////
    // Registered request
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            o_regf        <= '0;
            wr_level_prev <= 1'b0;
        end
        else
        begin
            o_regf.rd_en  <= i_rd_level;
            wr_level_prev <= i_wr_level;
            o_regf.wr_en  <= i_wr_level & ~wr_level_prev;   // One write per level

            case (i_regf_sel)
                SEL_BCR: o_regf.addr <= bcr_addr;
                SEL_MDB: o_regf.addr <= 12'(MDB_ADDR);
                default: o_regf.addr <= o_regf.addr;        // Hold last address
            endcase
        end
    end

    a_wr_single: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_regf.wr_en |=> !o_regf.wr_en);

endmodule

// ==== ibi_fsm.sv ====
`timescale 1ns/1ns

module ibi_fsm
(
    input  logic                   i_ibi_clk,
    input  logic                   i_ibi_rst_n,
    input  logic                   i_ibi_en,
    input  logic                   i_scl,
    input  logic                   i_scl_neg_edge,
    input  logic [7:0]             i_bcr_reg,
    input  ibi_pkg::ibi_cfg_t      i_cfg,
    input  logic                   i_payload_done,
    input  logic                   i_ser_mode_done,
    input  logic                   i_rx_done_d1,
    input  logic                   i_rx_done_d2,
    input  logic                   i_ser_done_pulse,
    output ibi_pkg::ibi_tx_ctrl_t  o_tx,
    output ibi_pkg::ibi_rx_ctrl_t  o_rx,
    output ibi_pkg::ibi_regf_sel_e o_regf_sel,
    output logic                   o_rd_level,
    output logic                   o_wr_level,
    output logic                   o_cnt_en,
    output logic                   o_payload_en,
    output logic                   o_ser_rx_tx,
    output logic                   o_done
);

    import ibi_pkg::*;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_ACK,
        ST_NACK,
        ST_MDB,
        ST_MDB_T_BIT,
        ST_PAYLOAD,
        ST_STOP
    } ibi_state_e;

    ibi_state_e state;

    ////////////////////////////////////////////////////////////
    // Register file address select
    ////////////////////////////////////////////////////////////

    // Decoded from the same conditions as the transitions so the port
    // registers the address on the edge that raises rd/wr
    always_comb
    begin
        o_regf_sel = SEL_HOLD;
        if (state == ST_IDLE && i_ibi_en && i_scl_neg_edge && i_cfg.ack_en)
            o_regf_sel = SEL_BCR;
        else if (state == ST_MDB && i_rx_done_d2)
            o_regf_sel = SEL_MDB;
    end

    ////////////////////////////////////////////////////////////
    // Main sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_ibi_clk or negedge i_ibi_rst_n)
    begin
        if (!i_ibi_rst_n)
        begin
            state        <= ST_IDLE;
            o_tx         <= '0;
            o_rx         <= '0;
            o_rd_level   <= 1'b0;
            o_wr_level   <= 1'b0;
            o_cnt_en     <= 1'b0;
            o_payload_en <= 1'b0;
            o_ser_rx_tx  <= 1'b0;
            o_done       <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;                             // Strobe by default
            case (state)
                ST_IDLE:
                begin
                    if (i_ibi_en && i_scl_neg_edge)     // ACK bit starts on SCL fall
                    begin
                        if (i_cfg.ack_en)
                        begin
                            o_rd_level   <= 1'b1;       // Fetch target BCR
                            o_tx.tx_en   <= 1'b1;
                            o_tx.pp_od   <= 1'b0;
                            o_tx.tx_mode <= DRIVE_LOW;  // Open-drain ACK
                            state        <= ST_ACK;
                        end
                        else
                        begin
                            o_tx.tx_en <= 1'b0;         // Leave SDA high for NACK
                            state      <= ST_NACK;
                        end
                    end
                end

                ST_ACK:
                begin
                    if (i_scl)
                    begin
                        if (i_bcr_reg[2])               // Target carries an MDB
                        begin
                            o_rd_level    <= 1'b0;
                            o_tx.tx_en    <= 1'b0;
                            o_tx.pp_od    <= 1'b1;
                            o_rx.rx_en    <= 1'b1;
                            o_rx.rx_mode  <= DESERIALIZE;
                            o_cnt_en      <= 1'b1;
                            state         <= ST_MDB;
                        end
                        else
                            state <= ST_STOP;
                    end
                end

                ST_NACK:
                begin
                    if (i_scl)
                        state <= ST_STOP;
                end

                ST_MDB:
                begin
                    if (i_rx_done_d1)
                        o_wr_level <= 1'b1;             // Store received MDB
                    if (i_rx_done_d2 && !i_scl)
                    begin
                        o_rx.rx_en   <= 1'b0;
                        o_cnt_en     <= 1'b0;
                        o_tx.tx_mode <= DRIVE_LOW;
                        state        <= ST_MDB_T_BIT;
                    end
                end

                ST_MDB_T_BIT:
                begin
                    o_wr_level <= 1'b0;
                    if (i_cfg.payload_en)
                    begin
                        o_payload_en <= 1'b1;           // Hand over to payload reader
                        o_ser_rx_tx  <= 1'b1;
                        state        <= ST_PAYLOAD;
                    end
                    else if (i_scl)
                        state <= ST_STOP;
                end

                ST_PAYLOAD:
                begin
                    if (i_payload_done)
                    begin
                        o_payload_en <= 1'b0;
                        o_ser_rx_tx  <= 1'b0;
                        o_tx         <= '0;
                        o_rx         <= '0;
                        o_rd_level   <= 1'b0;
                        o_done       <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end

                ST_STOP:
                begin
                    if (!i_scl)
                    begin
                        o_tx.tx_en   <= 1'b1;
                        o_tx.tx_mode <= STOP;
                    end
                    // Edge strobe covers a done level that drops before SCL rises
                    else if (i_ser_mode_done || i_ser_done_pulse)
                    begin
                        o_tx       <= '0;
                        o_rx       <= '0;
                        o_rd_level <= 1'b0;
                        o_done     <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    a_done_single: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        o_done |=> !o_done);

    a_tx_rx_excl: assert property (@(posedge i_ibi_clk) disable iff (!i_ibi_rst_n)
        !(o_tx.tx_en && o_rx.rx_en));

endmodule

// ==== ibi_top.sv ====
`timescale 1ns/1ns

module ibi_top
#(
    parameter int FIRST_TGT_ADDR = ibi_pkg::DEF_FIRST_TGT_ADDR,
    parameter int BCR_BASE       = ibi_pkg::DEF_BCR_BASE,
    parameter int MDB_ADDR       = ibi_pkg::DEF_MDB_ADDR
)
(
    input  logic                   i_ibi_clk,
    input  logic                   i_ibi_rst_n,
    input  logic                   i_ibi_en,
    input  logic                   i_ibi_scl,
    input  logic                   i_ibi_scl_neg_edge,
    input  logic                   i_ibi_payload_done,
    input  logic                   i_ibi_ser_mode_done,
    input  logic                   i_ibi_rx_mode_done,
    input  logic [7:0]             i_ibi_bcr_reg,
    input  ibi_pkg::ibi_cfg_t      i_ibi_cfg,
    input  logic [7:0]             i_ibi_tgt_address,
    output ibi_pkg::ibi_tx_ctrl_t  o_ibi_tx,
    output ibi_pkg::ibi_rx_ctrl_t  o_ibi_rx,
    output ibi_pkg::ibi_regf_req_t o_ibi_regf,
    output logic                   o_ibi_cnt_en,
    output logic                   o_ibi_payload_en,
    output logic                   o_ibi_ser_rx_tx,
    output logic                   o_ibi_done
);

    import ibi_pkg::*;

    logic          rx_done_d1;
    logic          rx_done_d2;
    logic          ser_done_pulse;
    ibi_regf_sel_e regf_sel;
    logic          rd_level;
    logic          wr_level;

    ibi_done_align u_done_align
    (
        .i_ibi_clk        (i_ibi_clk),
        .i_ibi_rst_n      (i_ibi_rst_n),
        .i_ser_mode_done  (i_ibi_ser_mode_done),
        .i_rx_mode_done   (i_ibi_rx_mode_done),
        .o_rx_done_d1     (rx_done_d1),
        .o_rx_done_d2     (rx_done_d2),
        .o_ser_done_pulse (ser_done_pulse)
    );

    ibi_regf_port #(.FIRST_TGT_ADDR(FIRST_TGT_ADDR), .BCR_BASE(BCR_BASE), .MDB_ADDR(MDB_ADDR))
    u_regf_port
    (
        .i_ibi_clk     (i_ibi_clk),
        .i_ibi_rst_n   (i_ibi_rst_n),
        .i_tgt_address (i_ibi_tgt_address),
        .i_regf_sel    (regf_sel),
        .i_rd_level    (rd_level),
        .i_wr_level    (wr_level),
        .o_regf        (o_ibi_regf)
    );

    ibi_fsm u_fsm
    (
        .i_ibi_clk        (i_ibi_clk),
        .i_ibi_rst_n      (i_ibi_rst_n),
        .i_ibi_en         (i_ibi_en),
        .i_scl            (i_ibi_scl),
        .i_scl_neg_edge   (i_ibi_scl_neg_edge),
        .i_bcr_reg        (i_ibi_bcr_reg),
        .i_cfg            (i_ibi_cfg),
        .i_payload_done   (i_ibi_payload_done),
        .i_ser_mode_done  (i_ibi_ser_mode_done),
        .i_rx_done_d1     (rx_done_d1),
        .i_rx_done_d2     (rx_done_d2),
        .i_ser_done_pulse (ser_done_pulse),
        .o_tx             (o_ibi_tx),
        .o_rx             (o_ibi_rx),
        .o_regf_sel       (regf_sel),
        .o_rd_level       (rd_level),
        .o_wr_level       (wr_level),
        .o_cnt_en         (o_ibi_cnt_en),
        .o_payload_en     (o_ibi_payload_en),
        .o_ser_rx_tx      (o_ibi_ser_rx_tx),
        .o_done           (o_ibi_done)
    );

endmodule

// ==== tb_ibi_checks.svh ====
`ifndef TB_IBI_CHECKS_SVH
`define TB_IBI_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

////////////////////////////////////////////////////////////
// Typed compares, one per kind of DUT result
////////////////////////////////////////////////////////////

task automatic check_tx
(
    input ibi_tx_ctrl_t actual,
    input ibi_tx_ctrl_t expected,
    input string        what
);
    if (actual !== expected)
    begin
        $display("FAIL %0t: %s, tx expected en=%0b pp=%0b mode=%0d, got en=%0b pp=%0b mode=%0d",
                 $time, what, expected.tx_en, expected.pp_od, expected.tx_mode,
                 actual.tx_en, actual.pp_od, actual.tx_mode);
        fail_count++;
    end
    else
        pass_count++;
endtask

task automatic check_rx
(
    input ibi_rx_ctrl_t actual,
    input ibi_rx_ctrl_t expected,
    input string        what
);
    if (actual !== expected)
    begin
        $display("FAIL %0t: %s, rx expected en=%0b mode=%0d, got en=%0b mode=%0d",
                 $time, what, expected.rx_en, expected.rx_mode,
                 actual.rx_en, actual.rx_mode);
        fail_count++;
    end
    else
        pass_count++;
endtask

task automatic check_regf
(
    input ibi_regf_req_t actual,
    input ibi_regf_req_t expected,
    input string         what
);
    if (actual !== expected)
    begin
        $display("FAIL %0t: %s, regf expected rd=%0b wr=%0b addr=%0d, got rd=%0b wr=%0b addr=%0d",
                 $time, what, expected.rd_en, expected.wr_en, expected.addr,
                 actual.rd_en, actual.wr_en, actual.addr);
        fail_count++;
    end
    else
        pass_count++;
endtask

task automatic check_bit
(
    input logic  actual,
    input logic  expected,
    input string what
);
    if (actual !== expected)
    begin
        $display("FAIL %0t: %s, expected %0b, got %0b", $time, what, expected, actual);
        fail_count++;
    end
    else
        pass_count++;
endtask

`endif

// ==== tb_ibi.sv ====
`timescale 1ns/1ns

module tb_ibi;

    import ibi_pkg::*;

    // Register map of the default build
    localparam int FIRST_TGT      = 8;
    localparam int BCR_BASE       = 206;
    localparam int MDB_ADDR       = 107;
    localparam int SCL_HALF       = 4;          // Clocks per SCL phase
    localparam int DONE_LIMIT     = 20;
    localparam int TEST_CYCLES    = 600;        // Rough length of the whole sequence
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 200;

    logic          i_ibi_clk;
    logic          i_ibi_rst_n;
    logic          i_ibi_en;
    logic          i_ibi_scl;
    logic          i_ibi_scl_neg_edge;
    logic          i_ibi_payload_done;
    logic          i_ibi_ser_mode_done;
    logic          i_ibi_rx_mode_done;
    logic [7:0]    i_ibi_bcr_reg;
    ibi_cfg_t      i_ibi_cfg;
    logic [7:0]    i_ibi_tgt_address;
    ibi_tx_ctrl_t  o_ibi_tx;
    ibi_rx_ctrl_t  o_ibi_rx;
    ibi_regf_req_t o_ibi_regf;
    logic          o_ibi_cnt_en;
    logic          o_ibi_payload_en;
    logic          o_ibi_ser_rx_tx;
    logic          o_ibi_done;

    int   cycle_count = 0;
    int   seed        = 48;
    int   last_addr   = 0;                      // Address the regf port should hold
    logic stop_seen   = 1'b0;

    `include "tb_ibi_checks.svh"

    ibi_top uut
    (
        .i_ibi_clk           (i_ibi_clk),
        .i_ibi_rst_n         (i_ibi_rst_n),
        .i_ibi_en            (i_ibi_en),
        .i_ibi_scl           (i_ibi_scl),
        .i_ibi_scl_neg_edge  (i_ibi_scl_neg_edge),
        .i_ibi_payload_done  (i_ibi_payload_done),
        .i_ibi_ser_mode_done (i_ibi_ser_mode_done),
        .i_ibi_rx_mode_done  (i_ibi_rx_mode_done),
        .i_ibi_bcr_reg       (i_ibi_bcr_reg),
        .i_ibi_cfg           (i_ibi_cfg),
        .i_ibi_tgt_address   (i_ibi_tgt_address),
        .o_ibi_tx            (o_ibi_tx),
        .o_ibi_rx            (o_ibi_rx),
        .o_ibi_regf          (o_ibi_regf),
        .o_ibi_cnt_en        (o_ibi_cnt_en),
        .o_ibi_payload_en    (o_ibi_payload_en),
        .o_ibi_ser_rx_tx     (o_ibi_ser_rx_tx),
        .o_ibi_done          (o_ibi_done)
    );

    initial
    begin
        i_ibi_clk = 1'b0;
        forever #5 i_ibi_clk = ~i_ibi_clk;
    end

    always @(posedge i_ibi_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run exceeded %0d clocks", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // Any STOP command on the line, sampled where outputs are stable
    always @(negedge i_ibi_clk)
    begin
        if (o_ibi_tx.tx_en && o_ibi_tx.tx_mode == STOP)
            stop_seen <= 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Expected value builders
    ////////////////////////////////////////////////////////////

    function automatic ibi_tx_ctrl_t tx_value(input logic en, input logic pp,
                                              input ibi_ser_mode_e mode);
        ibi_tx_ctrl_t v;
        v.tx_en   = en;
        v.pp_od   = pp;
        v.tx_mode = mode;
        return v;
    endfunction

    function automatic ibi_rx_ctrl_t rx_value(input logic en, input ibi_rx_mode_e mode);
        ibi_rx_ctrl_t v;
        v.rx_en   = en;
        v.rx_mode = mode;
        return v;
    endfunction

    function automatic ibi_regf_req_t regf_value(input logic rd, input logic wr, input int addr);
        ibi_regf_req_t v;
        v.rd_en = rd;
        v.wr_en = wr;
        v.addr  = addr[11:0];
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus and sequence helpers
    ////////////////////////////////////////////////////////////

    task automatic lower_scl();
        @(negedge i_ibi_clk);
        i_ibi_scl          = 1'b0;
        i_ibi_scl_neg_edge = 1'b1;                // One clock strobe on the fall
        @(negedge i_ibi_clk);
        i_ibi_scl_neg_edge = 1'b0;
        repeat (SCL_HALF - 2) @(negedge i_ibi_clk);
    endtask

    task automatic raise_scl();
        @(negedge i_ibi_clk);
        i_ibi_scl = 1'b1;
        repeat (SCL_HALF - 1) @(negedge i_ibi_clk);
    endtask

    task automatic await_done(input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit)
        begin
            @(negedge i_ibi_clk);
            n++;
            if (o_ibi_done)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("Missing pulse at %0t: o_ibi_done did not rise within %0d clocks",
                     $time, limit);
            fail_count++;
        end
        else
        begin
            @(negedge i_ibi_clk);
            check_bit(o_ibi_done, 1'b0, "done held past one clock");
        end
    endtask

    // SCL high with the serializer reporting the STOP sent
    task automatic finish_stop();
        @(negedge i_ibi_clk);
        i_ibi_scl           = 1'b1;
        i_ibi_ser_mode_done = 1'b1;
        await_done(DONE_LIMIT);
        i_ibi_ser_mode_done = 1'b0;
    endtask

    task automatic verify_idle();
        check_tx(o_ibi_tx, tx_value(1'b0, 1'b0, REP_START), "idle tx");
        check_rx(o_ibi_rx, rx_value(1'b0, RX_ACK), "idle rx");
        check_regf(o_ibi_regf, regf_value(1'b0, 1'b0, last_addr), "idle regf");
        check_bit(o_ibi_cnt_en, 1'b0, "idle cnt_en");
        check_bit(o_ibi_payload_en, 1'b0, "idle payload_en");
        check_bit(o_ibi_ser_rx_tx, 1'b0, "idle ser_rx_tx");
        check_bit(o_ibi_done, 1'b0, "idle done");
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%s finished with %0d error(s)", name, fail_count - fails_before);
    endtask

    // ACK with no MDB, ends through STOP
    task automatic ack_ibi_cycle(input logic [6:0] dyn_addr);
        int exp_addr;
        exp_addr          = BCR_BASE + 8 * (int'(dyn_addr) - FIRST_TGT);
        i_ibi_cfg         = '0;
        i_ibi_cfg.ack_en  = 1'b1;
        i_ibi_bcr_reg     = 8'h00;
        i_ibi_tgt_address = {dyn_addr, 1'b0};
        i_ibi_en          = 1'b1;
        lower_scl();
        check_tx(o_ibi_tx, tx_value(1'b1, 1'b0, DRIVE_LOW), "open-drain ACK");
        check_regf(o_ibi_regf, regf_value(1'b1, 1'b0, exp_addr), "BCR read address");
        last_addr = exp_addr;
        raise_scl();
        lower_scl();
        check_tx(o_ibi_tx, tx_value(1'b1, 1'b0, STOP), "STOP after ACK");
        finish_stop();
        verify_idle();
        i_ibi_en = 1'b0;
    endtask

    task automatic count_mdb_write();
        int pulses;
        int first_at;
        pulses   = 0;
        first_at = 0;
        for (int k = 1; k <= 8; k++)
        begin
            @(negedge i_ibi_clk);
            if (o_ibi_regf.wr_en)
            begin
                pulses++;
                if (first_at == 0)
                    first_at = k;
                check_regf(o_ibi_regf, regf_value(1'b0, 1'b1, MDB_ADDR), "MDB write");
            end
        end
        last_addr = MDB_ADDR;
        if (pulses == 0)
        begin
            $display("Missing pulse at %0t: no MDB write within 8 clocks of rx done", $time);
            fail_count++;
        end
        else if (pulses > 1)
        begin
            $display("At %0t the MDB write strobe was high %0d clocks, not one", $time, pulses);
            fail_count++;
        end
        else if (first_at < 2 || first_at > 5)
        begin
            $display("At %0t the MDB write came %0d clocks after rx done, not 2 to 5",
                     $time, first_at);
            fail_count++;
        end
        else
            pass_count++;
    endtask

    // ACK, then receive the MDB up to its T bit
    task automatic start_mdb_ibi(input logic payload);
        i_ibi_cfg            = '0;
        i_ibi_cfg.ack_en     = 1'b1;
        i_ibi_cfg.payload_en = payload;
        i_ibi_bcr_reg        = 8'h04;             // BCR bit 2, MDB follows
        i_ibi_tgt_address    = {7'h09, 1'b0};
        i_ibi_en             = 1'b1;
        lower_scl();
        check_regf(o_ibi_regf, regf_value(1'b1, 1'b0, BCR_BASE + 8), "BCR read before MDB");
        raise_scl();
        check_rx(o_ibi_rx, rx_value(1'b1, DESERIALIZE), "MDB receive");
        check_bit(o_ibi_cnt_en, 1'b1, "bit counter during MDB");
        check_tx(o_ibi_tx, tx_value(1'b0, 1'b1, DRIVE_LOW), "line released for MDB");
        repeat (3)                                // Shortened MDB bit train
        begin
            lower_scl();
            raise_scl();
        end
        lower_scl();
        i_ibi_rx_mode_done = 1'b1;
        count_mdb_write();
        check_rx(o_ibi_rx, rx_value(1'b0, DESERIALIZE), "deserializer off after MDB");
        check_bit(o_ibi_cnt_en, 1'b0, "bit counter off after MDB");
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        int fails_before;
        fails_before = fail_count;
        @(negedge i_ibi_clk);
        verify_idle();
        report_test("test_reset", fails_before);
    endtask

    task automatic test_nack_stop();
        int fails_before;
        fails_before = fail_count;
        @(negedge i_ibi_clk);
        i_ibi_cfg         = '0;                   // Controller NACKs
        i_ibi_tgt_address = {7'h0B, 1'b0};
        i_ibi_en          = 1'b1;
        lower_scl();
        check_tx(o_ibi_tx, tx_value(1'b0, 1'b0, REP_START), "NACK bit low phase");
        raise_scl();
        check_tx(o_ibi_tx, tx_value(1'b0, 1'b0, REP_START), "NACK bit high phase");
        lower_scl();
        check_tx(o_ibi_tx, tx_value(1'b1, 1'b0, STOP), "STOP after NACK");
        finish_stop();
        verify_idle();
        i_ibi_en = 1'b0;
        report_test("test_nack_stop", fails_before);
    endtask

    task automatic test_ack_no_mdb();
        int fails_before;
        fails_before = fail_count;
        @(negedge i_ibi_clk);
        ack_ibi_cycle(7'h0A);
        report_test("test_ack_no_mdb", fails_before);
    endtask

    task automatic test_mdb_terminate();
        int fails_before;
        fails_before = fail_count;
        @(negedge i_ibi_clk);
        start_mdb_ibi(1'b0);
        i_ibi_rx_mode_done = 1'b0;
        raise_scl();                              // T bit ends, STOP follows
        lower_scl();
        check_tx(o_ibi_tx, tx_value(1'b1, 1'b1, STOP), "STOP after MDB");
        finish_stop();
        verify_idle();
        i_ibi_en = 1'b0;
        report_test("test_mdb_terminate", fails_before);
    endtask

    task automatic test_mdb_payload();
        int fails_before;
        fails_before = fail_count;
        @(negedge i_ibi_clk);
        stop_seen = 1'b0;
        start_mdb_ibi(1'b1);
        check_bit(o_ibi_payload_en, 1'b1, "payload handover");
        check_bit(o_ibi_ser_rx_tx, 1'b1, "serializer turned to payload");
        repeat (5)
        begin
            @(negedge i_ibi_clk);
            check_bit(o_ibi_payload_en, 1'b1, "payload_en held");
            check_bit(o_ibi_ser_rx_tx, 1'b1, "ser_rx_tx held");
        end
        i_ibi_rx_mode_done = 1'b0;
        i_ibi_payload_done = 1'b1;
        await_done(DONE_LIMIT);
        i_ibi_payload_done = 1'b0;
        verify_idle();
        check_bit(stop_seen, 1'b0, "STOP issued on payload path");
        i_ibi_en = 1'b0;
        report_test("test_mdb_payload", fails_before);
    endtask

    task automatic test_bcr_address_sweep();
        int         fails_before;
        int         r;
        logic [6:0] dyn_addr;
        fails_before = fail_count;
        @(negedge i_ibi_clk);
        repeat (8)
        begin
            r        = $random(seed);
            dyn_addr = 7'(FIRST_TGT + (r & 7));   // Targets 08 to 0F
            ack_ibi_cycle(dyn_addr);
        end
        report_test("test_bcr_address_sweep", fails_before);
    endtask

    initial
    begin
        i_ibi_rst_n         = 1'b0;
        i_ibi_en            = 1'b0;
        i_ibi_scl           = 1'b1;
        i_ibi_scl_neg_edge  = 1'b0;
        i_ibi_payload_done  = 1'b0;
        i_ibi_ser_mode_done = 1'b0;
        i_ibi_rx_mode_done  = 1'b0;
        i_ibi_bcr_reg       = 8'h00;
        i_ibi_cfg           = '0;
        i_ibi_tgt_address   = 8'h00;
        repeat (10) @(negedge i_ibi_clk);
        i_ibi_rst_n = 1'b1;

        test_reset();
        test_nack_stop();
        test_ack_no_mdb();
        test_mdb_terminate();
        test_mdb_payload();
        test_bcr_address_sweep();

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
ibi_pkg.sv
ibi_done_align.sv
ibi_regf_port.sv
ibi_fsm.sv
ibi_top.sv
tb_ibi.sv
